// ==== logic/gamma_pkg.sv ====
package gamma_pkg;

  localparam int unsigned stream_data_w = 32;

  typedef struct packed {
    logic [stream_data_w-1:0]   tdata;
    logic [stream_data_w/8-1:0] tkeep;
    logic                       tlast;
    logic                       tuser;  // start of frame
    logic                       tvalid;
  } axis_beat_t;

  typedef struct packed {
    logic        awvalid;
    logic [31:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [31:0] araddr;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  localparam logic [31:0] reg_ctrl_off = 32'h0;
  localparam logic [31:0] reg_lut_off  = 32'h4;
  localparam logic [31:0] reg_last_off = 32'h8;  // table write count

  typedef struct packed {
    logic [30:0] rsvd;
    logic        enable;
  } ctrl_word_t;

  typedef struct packed {
    logic [15:0] index;
    logic [15:0] value;
  } lut_word_t;

  typedef union packed {
    ctrl_word_t ctrl;
    lut_word_t  lut;
  } csr_word_u;

  typedef struct packed {
    logic        we;
    logic [15:0] addr;
    logic [15:0] data;
  } lut_wr_t;

endpackage

// ==== logic/gamma_csr.sv ====
`timescale 1ns/10ps

module gamma_csr import gamma_pkg::*; #(
  parameter logic [31:0] CSR_BASE_ADDR = 32'h0,
  parameter int unsigned PX_WIDTH      = 10
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  axil_req_t csr_req_i,
  output axil_rsp_t csr_rsp_o,
  output lut_wr_t   lut_wr_o,
  output logic      enable_o
);

  logic [31:0] wr_off;
  logic [31:0] rd_off;
  logic        wr_hs;
  logic        rd_hs;
  logic        wr_hit;
  logic        rd_hit;
  csr_word_u   wr_word;
  csr_word_u   rd_word;
  logic        bvalid_q;
  logic [1:0]  bresp_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic [1:0]  rresp_q;
  logic        enable_q;
  logic        lut_we_q;
  logic [15:0] lut_addr_q;
  logic [15:0] lut_data_q;
  logic [31:0] last_word_q;
  logic [15:0] wr_cnt_q;

  assign wr_off  = csr_req_i.awaddr - CSR_BASE_ADDR;
  assign rd_off  = csr_req_i.araddr - CSR_BASE_ADDR;
  assign wr_word = csr_word_u'(csr_req_i.wdata);

  // address and data are taken together, one write in flight
  assign wr_hs  = csr_req_i.awvalid & csr_req_i.wvalid & ~bvalid_q;
  assign rd_hs  = csr_req_i.arvalid & ~rvalid_q;
  assign wr_hit = (wr_off == reg_ctrl_off) || (wr_off == reg_lut_off) ||
                  (wr_off == reg_last_off);  // count reg ignores writes

  always_comb begin
    rd_word = '0;
    rd_hit  = 1'b1;
    case (rd_off)
      reg_ctrl_off: rd_word.ctrl.enable = enable_q;
      reg_lut_off:  rd_word = csr_word_u'(last_word_q);
      reg_last_off: rd_word = csr_word_u'(32'(wr_cnt_q));
      default:      rd_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q    <= 1'b0;
      enable_q    <= 1'b0;
      lut_we_q    <= 1'b0;
      last_word_q <= '0;
      wr_cnt_q    <= '0;
    end else begin
      lut_we_q <= 1'b0;  // single cycle strobe
      if (wr_hs) begin
        bvalid_q <= 1'b1;
        if (wr_off == reg_ctrl_off) begin
          enable_q <= wr_word.ctrl.enable;
        end
        if (wr_off == reg_lut_off) begin
          lut_we_q    <= 1'b1;
          last_word_q <= wr_word;
          wr_cnt_q    <= wr_cnt_q + 16'd1;  // wraps at 2^16
        end
      end else if (csr_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_hs) begin
      rvalid_q <= 1'b1;
    end else if (csr_req_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      bresp_q    <= wr_hit ? resp_okay : resp_slverr;
      lut_addr_q <= 16'(wr_word.lut.index[PX_WIDTH-1:0]);  // drop bits above px width
      lut_data_q <= 16'(wr_word.lut.value[PX_WIDTH-1:0]);
    end
    if (rd_hs) begin
      rdata_q <= rd_word;
      rresp_q <= rd_hit ? resp_okay : resp_slverr;
    end
  end

  assign csr_rsp_o = '{
    awready: wr_hs,
    wready:  wr_hs,
    bvalid:  bvalid_q,
    bresp:   bresp_q,
    arready: ~rvalid_q,
    rvalid:  rvalid_q,
    rdata:   rdata_q,
    rresp:   rresp_q
  };

  assign lut_wr_o = '{we: lut_we_q, addr: lut_addr_q, data: lut_data_q};
  assign enable_o = enable_q;

endmodule

// ==== logic/gamma_lut_ram.sv ====
`timescale 1ns/10ps

module gamma_lut_ram import gamma_pkg::*; #(
  parameter int unsigned PX_WIDTH = 10
) (
  input  logic                     clk_i,
  input  lut_wr_t                  lut_wr_i,
  input  logic [2:0][PX_WIDTH-1:0] rd_addr_i,
  output logic [2:0][PX_WIDTH-1:0] rd_data_o,
  input  logic                     rd_en_i
);

  localparam int unsigned DEPTH = 2 ** PX_WIDTH;

  logic [PX_WIDTH-1:0] mem_q [DEPTH];

  // single write port, shared by all three channels
  always_ff @(posedge clk_i) begin
    if (lut_wr_i.we) begin
      mem_q[lut_wr_i.addr[PX_WIDTH-1:0]] <= lut_wr_i.data[PX_WIDTH-1:0];
    end
  end

  // read ports hold their data while the pipe is stalled
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      for (int c = 0; c < 3; c++) begin
        rd_data_o[c] <= mem_q[rd_addr_i[c]];
      end
    end
  end

endmodule

// ==== logic/gamma_corrector.sv ====
`timescale 1ns/10ps

module gamma_corrector import gamma_pkg::*; #(
  parameter int unsigned PX_WIDTH = 10
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     enable_i,
  input  axis_beat_t               video_i,
  output logic                     video_ready_o,
  output axis_beat_t               video_o,
  input  logic                     video_ready_i,
  output logic [2:0][PX_WIDTH-1:0] lut_addr_o,
  input  logic [2:0][PX_WIDTH-1:0] lut_data_i,
  output logic                     lut_en_o
);

  axis_beat_t               s1_q;     // beat waiting on its table lookups
  logic                     s1_en_q;
  axis_beat_t               s2_beat;
  axis_beat_t               out_q;
  logic [stream_data_w-1:0] px_word;
  logic                     advance;

  // whole pipe moves or stalls as one
  assign advance       = ~out_q.tvalid | video_ready_i;
  assign video_ready_o = advance;
  assign lut_en_o      = advance;

  // stage 1: channel split straight into the table read ports
  always_comb begin
    for (int c = 0; c < 3; c++) begin
      lut_addr_o[c] = video_i.tdata[c*PX_WIDTH +: PX_WIDTH];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_q    <= '0;
      s1_en_q <= 1'b0;
    end else if (advance) begin
      s1_q    <= video_i;
      s1_en_q <= enable_i;  // enable follows the beat
    end
  end

  // stage 2: swap in the table values, upper bits untouched
  always_comb begin
    px_word = s1_q.tdata;
    if (s1_en_q) begin
      for (int c = 0; c < 3; c++) begin
        px_word[c*PX_WIDTH +: PX_WIDTH] = lut_data_i[c];
      end
    end
  end

  always_comb begin
    s2_beat       = s1_q;
    s2_beat.tdata = px_word;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
    end else if (advance) begin
      out_q <= s2_beat;
    end
  end

  assign video_o = out_q;

endmodule

// ==== logic/gamma_corrector_top.sv ====
`timescale 1ns/10ps

module gamma_corrector_top import gamma_pkg::*; #(
  parameter logic [31:0] CSR_BASE_ADDR = 32'h0,
  parameter int unsigned PX_WIDTH      = 10
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  axil_req_t  csr_req_i,
  output axil_rsp_t  csr_rsp_o,
  input  axis_beat_t video_i,
  output logic       video_ready_o,
  output axis_beat_t video_o,
  input  logic       video_ready_i
);

  lut_wr_t                  lut_wr;
  logic                     enable;
  logic [2:0][PX_WIDTH-1:0] lut_addr;
  logic [2:0][PX_WIDTH-1:0] lut_data;
  logic                     lut_en;

  gamma_csr #(
    .CSR_BASE_ADDR ( CSR_BASE_ADDR ),
    .PX_WIDTH      ( PX_WIDTH      )
  ) i_gamma_csr (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .csr_req_i     ( csr_req_i     ),
    .csr_rsp_o     ( csr_rsp_o     ),
    .lut_wr_o      ( lut_wr        ),
    .enable_o      ( enable        )
  );

  gamma_lut_ram #(
    .PX_WIDTH  ( PX_WIDTH )
  ) i_gamma_lut_ram (
    .clk_i     ( clk_i    ),
    .lut_wr_i  ( lut_wr   ),
    .rd_addr_i ( lut_addr ),
    .rd_data_o ( lut_data ),
    .rd_en_i   ( lut_en   )
  );

  gamma_corrector #(
    .PX_WIDTH      ( PX_WIDTH      )
  ) i_gamma_corrector (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .enable_i      ( enable        ),
    .video_i       ( video_i       ),
    .video_ready_o ( video_ready_o ),
    .video_o       ( video_o       ),
    .video_ready_i ( video_ready_i ),
    .lut_addr_o    ( lut_addr      ),
    .lut_data_i    ( lut_data      ),
    .lut_en_o      ( lut_en        )
  );

endmodule

// ==== dv/gamma_corrector_chk.sv ====
`timescale 1ns/10ps

module gamma_corrector_chk import gamma_pkg::*; (
  input logic       clk_i,
  input logic       rst_n_i,
  input axil_req_t  csr_req_i,
  input axil_rsp_t  csr_rsp_i,
  input axis_beat_t out_beat_i,
  input logic       out_ready_i
);

  stream_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_beat_i.tvalid && !out_ready_i |=> out_beat_i.tvalid && $stable(out_beat_i))
    else $error("output beat changed or dropped before it was taken");

  bresp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csr_rsp_i.bvalid && !csr_req_i.bready |=> csr_rsp_i.bvalid && $stable(csr_rsp_i.bresp))
    else $error("write response changed or dropped before bready");

  rresp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csr_rsp_i.rvalid && !csr_req_i.rready |=>
      csr_rsp_i.rvalid && $stable({csr_rsp_i.rdata, csr_rsp_i.rresp}))
    else $error("read response changed or dropped before rready");

  resp_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> !csr_rsp_i.bvalid && !csr_rsp_i.rvalid)
    else $error("bvalid or rvalid high during reset");

  aw_w_paired: assert property (@(posedge clk_i) csr_rsp_i.awready == csr_rsp_i.wready)
    else $error("awready and wready differ");

endmodule

bind gamma_corrector_top gamma_corrector_chk i_gamma_corrector_chk (
  .clk_i       ( clk_i         ),
  .rst_n_i     ( rst_n_i       ),
  .csr_req_i   ( csr_req_i     ),
  .csr_rsp_i   ( csr_rsp_o     ),
  .out_beat_i  ( video_o       ),
  .out_ready_i ( video_ready_i )
);

// ==== dv/gamma_corrector_tb.sv ====
`timescale 1ns/10ps

module gamma_corrector_tb import gamma_pkg::*; ();

  localparam logic [31:0] base_addr  = 32'h4000_0000;
  localparam string       tests_file = "dv/gamma_tests.txt";

  typedef struct packed {
    logic [7:0]       code;
    logic [7:0][31:0] arg;
  } test_op_t;

  logic       clk;
  logic       rst_n;
  axil_req_t  csr_req;
  axil_rsp_t  csr_rsp;
  axis_beat_t video_in;
  logic       video_in_ready;
  axis_beat_t video_out;
  logic       video_out_ready;

  test_op_t   ops[$];
  axis_beat_t exp_q[$];
  int         hs_cyc_q[$];  // cycle of each input handshake
  int         cyc;
  int         cyc_limit;
  int         last_stall_cyc;
  logic       stall_en;
  logic       out_busy;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  gamma_corrector_top #(
    .CSR_BASE_ADDR ( base_addr ),
    .PX_WIDTH      ( 10        )
  ) i_gamma_corrector_top (
    .clk_i         ( clk             ),
    .rst_n_i       ( rst_n           ),
    .csr_req_i     ( csr_req         ),
    .csr_rsp_o     ( csr_rsp         ),
    .video_i       ( video_in        ),
    .video_ready_o ( video_in_ready  ),
    .video_o       ( video_out       ),
    .video_ready_i ( video_out_ready )
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic load_tests();
    int          fd;
    int          n_lines;
    string       line;
    logic [7:0]  code;
    logic [31:0] a [8];
    test_op_t    op;
    fd = $fopen(tests_file, "r");
    assert (fd != 0) else stop_on_error("could not open the tests file");
    n_lines = 0;
    while ($fgets(line, fd) != 0) begin
      n_lines++;
      code = 8'h0;
      foreach (a[i]) a[i] = '0;
      void'($sscanf(line, "%c %h %h %h %h %h %h %h %h",
                    code, a[0], a[1], a[2], a[3], a[4], a[5], a[6], a[7]));
      if (code inside {"W", "R", "P", "I", "S"}) begin  // skips comments and blank lines
        op.code = code;
        foreach (a[i]) op.arg[i] = a[i];
        ops.push_back(op);
      end
    end
    $fclose(fd);
    cyc_limit = 20 * n_lines + 200;
  endtask

  // all drive tasks start and end 0.5 ns after a rising edge
  task automatic send_beat(input test_op_t op);
    axis_beat_t exp_beat;
    exp_beat = '{tdata: op.arg[4], tkeep: op.arg[5][3:0], tlast: op.arg[6][0],
                 tuser: op.arg[7][0], tvalid: 1'b1};
    video_in = '{tdata: op.arg[0], tkeep: op.arg[1][3:0], tlast: op.arg[2][0],
                 tuser: op.arg[3][0], tvalid: 1'b1};
    do @(negedge clk); while (!video_in_ready);
    exp_q.push_back(exp_beat);
    hs_cyc_q.push_back(cyc);
    @(posedge clk);
    #0.5;
    video_in.tvalid = 1'b0;
  endtask

  task automatic write_reg(input test_op_t op);
    csr_req.awvalid = 1'b1;
    csr_req.awaddr  = op.arg[0];
    csr_req.wvalid  = 1'b1;
    csr_req.wdata   = op.arg[1];
    csr_req.bready  = 1'b0;  // response waits one cycle
    do @(negedge clk); while (!(csr_rsp.awready && csr_rsp.wready));
    @(posedge clk);
    #0.5;
    csr_req.awvalid = 1'b0;
    csr_req.wvalid  = 1'b0;
    do @(negedge clk); while (!csr_rsp.bvalid);
    assert (csr_rsp.bresp == op.arg[2][1:0])
      else stop_on_error($sformatf("error: bresp got %h expected %h",
                                   csr_rsp.bresp, op.arg[2][1:0]));
    @(posedge clk);
    #0.5;
    csr_req.bready = 1'b1;
    @(posedge clk);
    #0.5;
  endtask

  task automatic read_reg(input test_op_t op);
    csr_req.arvalid = 1'b1;
    csr_req.araddr  = op.arg[0];
    csr_req.rready  = 1'b0;  // response waits one cycle
    do @(negedge clk); while (!csr_rsp.arready);
    @(posedge clk);
    #0.5;
    csr_req.arvalid = 1'b0;
    do @(negedge clk); while (!csr_rsp.rvalid);
    assert (csr_rsp.rresp == op.arg[2][1:0])
      else stop_on_error($sformatf("error: rresp got %h expected %h",
                                   csr_rsp.rresp, op.arg[2][1:0]));
    if (op.arg[2][1:0] == resp_okay) begin  // rdata means nothing on slverr
      assert (csr_rsp.rdata == op.arg[1])
        else stop_on_error($sformatf("error: rdata got %h expected %h",
                                     csr_rsp.rdata, op.arg[1]));
    end
    @(posedge clk);
    #0.5;
    csr_req.rready = 1'b1;
    @(posedge clk);
    #0.5;
  endtask

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > cyc_limit) begin
      stop_on_error($sformatf("timeout: the run did not finish within %0d cycles", cyc_limit));
    end
  end

  // random back-pressure, about 30% stall when enabled
  initial begin
    video_out_ready = 1'b1;
    void'($urandom(32'hade6));
    forever begin
      @(posedge clk);
      #0.5;
      video_out_ready = ($urandom_range(9) > 2) || !stall_en;
    end
  end

  always @(negedge clk) begin : collect_out
    axis_beat_t exp_beat;
    if (rst_n) begin
      if (video_out.tvalid && !out_busy) begin  // first cycle of a new output beat
        assert (exp_q.size() != 0)
          else stop_on_error("an output beat arrived with none expected");
        if (last_stall_cyc < hs_cyc_q[0]) begin
          assert (cyc == hs_cyc_q[0] + 2)
            else stop_on_error($sformatf("error: video_o.tvalid latency got %h expected %h",
                                         cyc - hs_cyc_q[0], 2));
        end
      end
      if (!video_out_ready) last_stall_cyc = cyc;
      out_busy = video_out.tvalid && !video_out_ready;
      if (video_out.tvalid && video_out_ready) begin
        exp_beat = exp_q.pop_front();
        void'(hs_cyc_q.pop_front());
        assert (video_out.tdata == exp_beat.tdata)
          else stop_on_error($sformatf("error: video_o.tdata got %h expected %h",
                                       video_out.tdata, exp_beat.tdata));
        assert ({video_out.tkeep, video_out.tlast, video_out.tuser} ==
                {exp_beat.tkeep, exp_beat.tlast, exp_beat.tuser})
          else stop_on_error($sformatf("error: video_o {tkeep,tlast,tuser} got %h expected %h",
                                       {video_out.tkeep, video_out.tlast, video_out.tuser},
                                       {exp_beat.tkeep, exp_beat.tlast, exp_beat.tuser}));
      end
    end
  end

  initial begin
    rst_n           = 1'b0;
    csr_req         = '0;
    csr_req.wstrb   = 4'hf;
    csr_req.bready  = 1'b1;
    csr_req.rready  = 1'b1;
    video_in        = '0;
    stall_en        = 1'b0;
    out_busy        = 1'b0;
    cyc             = 0;
    cyc_limit       = 200;
    last_stall_cyc  = -1;
    load_tests();
    repeat (3) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    foreach (ops[i]) begin
      case (ops[i].code)
        "W": write_reg(ops[i]);
        "R": read_reg(ops[i]);
        "P": send_beat(ops[i]);
        "S": stall_en = ops[i].arg[0][0];
        default: begin
          repeat (ops[i].arg[0]) @(posedge clk);
          #0.5;
        end
      endcase
    end
    while (exp_q.size() != 0) @(posedge clk);  // drain the pipe
    repeat (2) @(posedge clk);
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== gamma_corr.f ====
logic/gamma_pkg.sv
logic/gamma_csr.sv
logic/gamma_lut_ram.sv
logic/gamma_corrector.sv
logic/gamma_corrector_top.sv
dv/gamma_corrector_chk.sv
dv/gamma_corrector_tb.sv

// ==== Bender.yml ====
package:
  name: gamma_corr

sources:
  - logic/gamma_pkg.sv
  - logic/gamma_csr.sv
  - logic/gamma_lut_ram.sv
  - logic/gamma_corrector.sv
  - logic/gamma_corrector_top.sv
  - target: test
    files:
      - dv/gamma_corrector_chk.sv
      - dv/gamma_corrector_tb.sv

// ==== dv/gamma_tests.txt ====
# op W: addr wdata bresp | R: addr rdata rresp | I: idle cycles | S: random stall on/off
# op P: tdata tkeep tlast tuser, then expected tdata tkeep tlast tuser (all hex)
P C0A81234 F 0 1 C0A81234 F 0 1
P 7FFFFFFF 3 1 0 7FFFFFFF 3 1 0
R 40000000 00000000 0
W 40000004 00000200 0
W 40000004 00010155 0
W 40000004 000202AA 0
W 40000004 000303FF 0
W 40000004 03FF0001 0
W 40000004 04048123 0
R 40000004 04048123 0
R 40000008 00000006 0
W 40000000 00000001 0
R 40000000 00000001 0
W 4000000C 12345678 2
R 40000010 00000000 2
P 00300801 F 1 1 3FFAA955 F 1 1
I 6
S 1
P 00300801 F 0 1 3FFAA955 F 0 1
P 40100004 F 0 0 55580123 F 0 0
P 80000FFF F 0 0 A00FFC01 F 0 0
P FFF01002 F 0 0 C0148EAA F 0 0
P 00300C03 F 0 0 3FFFFFFF F 0 0
P 40000000 F 0 0 60080200 F 0 0
P 80100401 F 0 0 95555555 F 0 0
P 00200802 7 0 0 2AAAAAAA 7 0 0
P C0401004 F 0 0 D2348D23 F 0 0
P 3FFFFFFF F 0 0 00100401 F 0 0
P 40400003 F 0 0 523803FF F 0 0
P BFF00400 F 0 0 80155600 F 0 0
P C0200C04 F 0 0 EAAFFD23 F 0 0
P 000FFC01 F 0 0 20000555 F 0 0
P 40400402 F 0 0 523556AA F 0 0
P 80100BFF 3 1 0 955AA801 3 1 0
S 0
P 00300C03 F 0 0 3FFFFFFF F 0 0
W 40000000 00000000 0
P 00300C03 F 1 0 00300C03 F 1 0
